// ==== relay_pkg.sv ====
//**************************************************************************
// shared definitions for the relay computer control unit: state count,
// class and register codes, opcodes, instruction word views, lengths
//**************************************************************************
package relay_pkg;

	localparam int num_states = 24;

	// instruction lengths in timing states
	localparam int len_short = 8; // mov8, setab, alu
	localparam int len_mem = 12; // mem, mov16, return
	localparam int len_inc = 14;
	localparam int len_goto = 24;

	// class prefixes taken from the top of the instruction byte
	localparam logic [1:0] pfx_mov8 = 2'b00;
	localparam logic [1:0] pfx_setab = 2'b01;
	localparam logic [1:0] pfx_goto = 2'b11;
	localparam logic [3:0] pfx_alu = 4'b1000;
	localparam logic [3:0] pfx_mem = 4'b1001;
	localparam logic [3:0] pfx_mov16 = 4'b1010;
	localparam logic [3:0] pfx_inc = 4'b1011;

	localparam logic [7:0] op_halt = 8'hAE; // both inside the mov16 class
	localparam logic [7:0] op_return = 8'hAA;

	localparam logic [2:0] alu_nop = 3'b111;

	typedef enum logic [2:0] {
		mov8,
		setab,
		goto_op,
		alu,
		mem,
		mov16,
		inc
	} inst_class_t;

	typedef enum logic [2:0] {
		a,
		b,
		c,
		d,
		m1,
		m2,
		x,
		y
	} reg_code_t;

	typedef struct packed {
		logic [1:0] cls;
		reg_code_t dst;
		reg_code_t src;
	} mov8_view_t;

	typedef struct packed {
		logic [1:0] cls;
		logic dst_b;
		logic [4:0] imm;
	} setab_view_t;

	typedef struct packed {
		logic [3:0] cls;
		logic dst_d;
		logic [2:0] func;
	} alu_view_t;

	typedef struct packed {
		logic [3:0] cls;
		logic store;
		logic unused;
		logic [1:0] rsel; // a to d only
	} mem_view_t;

	typedef struct packed {
		logic [3:0] cls;
		logic to_xy;
		logic from_j;
		logic [1:0] unused;
	} mov16_view_t;

	typedef struct packed {
		logic [1:0] cls;
		logic to_j;
		logic c_sign;
		logic c_carry;
		logic c_zero;
		logic c_nonzero;
		logic call;
	} goto_view_t;

	// one instruction byte, one view per field layout
	typedef union packed {
		mov8_view_t as_mov8;
		setab_view_t as_setab;
		alu_view_t as_alu;
		mem_view_t as_mem;
		mov16_view_t as_mov16;
		goto_view_t as_goto;
	} inst_word_t;

endpackage

// ==== inst_classifier.sv ====
//**************************************************************************
// instruction register with class decode and field extraction
//**************************************************************************
module inst_classifier (
	input logic clk,
	input logic arst_n,
	input logic ld_inst,
	input logic [7:0] data_in,
	output relay_pkg::inst_word_t inst,
	output relay_pkg::inst_class_t inst_class
);
	import relay_pkg::*;

	// instruction register, loaded from the bus during state 2
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			inst <= '0; // mov8 a to a
		end
		else if (ld_inst)
		begin
			inst <= data_in;
		end
	end

	// two-bit prefixes first, then the 10xx group
	always_comb
	begin
		inst_class = mov8;
		case (inst.as_mov8.cls)
			pfx_mov8:
				inst_class = mov8;
			pfx_setab:
				inst_class = setab;
			pfx_goto:
				inst_class = goto_op;
			default:
			begin
				case (inst.as_alu.cls)
					pfx_alu:
						inst_class = alu;
					pfx_mem:
						inst_class = mem;
					pfx_mov16:
						inst_class = mov16;
					pfx_inc:
						inst_class = inc;
					default:
						inst_class = mov8;
				endcase
			end
		endcase
	end

endmodule

// ==== state_sequencer.sv ====
//**************************************************************************
// one-hot timing-state sequencer with end-of-instruction wrap and halt latch
//**************************************************************************
module state_sequencer (
	input logic clk,
	input logic arst_n,
	input relay_pkg::inst_word_t inst,
	input relay_pkg::inst_class_t inst_class,
	output logic [relay_pkg::num_states-1:0] state
);
	import relay_pkg::*;

	logic halt_q;
	logic is_halt;
	logic at_end;
	logic [num_states-1:0] state_next;

	assign is_halt = (inst == op_halt);

	// last state of the current instruction
	always_comb
	begin
		case (inst_class)
			mov8, setab, alu:
				at_end = state[len_short-1];
			mem, mov16:
				at_end = state[len_mem-1]; // return and halt share this
			inc:
				at_end = state[len_inc-1];
			goto_op:
				at_end = state[len_goto-1];
			default:
				at_end = state[len_short-1];
		endcase
	end

	always_comb
	begin
		if (halt_q)
		begin
			state_next = state; // parked in state 10
		end
		else if (at_end)
		begin
			state_next = num_states'(1);
		end
		else
		begin
			state_next = {state[num_states-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= num_states'(1); // fetch
		end
		else
		begin
			state <= state_next;
		end
	end

	// set when leaving state 9 on a halt opcode
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			halt_q <= 1'b0;
		end
		else if (state[8] && is_halt)
		begin
			halt_q <= 1'b1;
		end
	end

endmodule

// ==== control_decode.sv ====
//**************************************************************************
// strobe generation from the timing state and the decoded instruction
//**************************************************************************
module control_decode (
	input logic [relay_pkg::num_states-1:0] state,
	input relay_pkg::inst_word_t inst,
	input relay_pkg::inst_class_t inst_class,
	input logic zero,
	input logic carry,
	input logic sign,
	output logic [7:0] reg_load,
	output logic [7:0] reg_select,
	output logic ld_inst,
	output logic ld_inc,
	output logic ld_pc,
	output logic ld_xy,
	output logic ld_j1,
	output logic ld_j2,
	output logic ld_cond,
	output logic sel_pc,
	output logic sel_inc,
	output logic sel_m,
	output logic sel_j,
	output logic sel_xy,
	output logic mem_read,
	output logic mem_write,
	output logic data_drive,
	output logic halt,
	output logic [2:0] alu_func,
	output logic [7:0] data_out
);
	import relay_pkg::*;

	logic [num_states:1] s; // s[n] is timing state n
	logic cond_set;
	logic branch_taken;

	assign s = state;

	assign cond_set = inst.as_goto.c_sign | inst.as_goto.c_carry |
		inst.as_goto.c_zero | inst.as_goto.c_nonzero;

	// unconditional when no condition bit is set
	assign branch_taken = !cond_set ||
		(inst.as_goto.c_sign && sign) ||
		(inst.as_goto.c_carry && carry) ||
		(inst.as_goto.c_zero && zero) ||
		(inst.as_goto.c_nonzero && !zero);

	always_comb
	begin
		reg_load = '0;
		reg_select = '0;
		ld_inst = 1'b0;
		ld_inc = 1'b0;
		ld_pc = 1'b0;
		ld_xy = 1'b0;
		ld_j1 = 1'b0;
		ld_j2 = 1'b0;
		ld_cond = 1'b0;
		sel_pc = 1'b0;
		sel_inc = 1'b0;
		sel_m = 1'b0;
		sel_j = 1'b0;
		sel_xy = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		data_drive = 1'b0;
		halt = 1'b0;
		alu_func = alu_nop;
		data_out = '0;

		// fetch, common to every instruction
		if (s[1] || s[2] || s[3])
		begin
			sel_pc = 1'b1;
			mem_read = 1'b1;
		end
		if (s[2])
		begin
			ld_inst = 1'b1;
			ld_inc = 1'b1;
		end
		if (s[5])
		begin
			sel_inc = 1'b1; // pc step
			ld_pc = 1'b1;
		end

		case (inst_class)
			mov8:
			begin
				if (s[5] || s[6])
					reg_select[inst.as_mov8.src] = 1'b1;
				if (s[5])
					reg_load[inst.as_mov8.dst] = 1'b1;
			end
			alu:
			begin
				if (s[4] || s[5] || s[6])
					alu_func = inst.as_alu.func;
				if (s[5])
					reg_load[inst.as_alu.dst_d ? d : a] = 1'b1;
			end
			setab:
			begin
				if (s[4] || s[5] || s[6])
				begin
					data_out = {{3{inst.as_setab.imm[4]}}, inst.as_setab.imm};
					data_drive = 1'b1;
				end
				if (s[5])
				begin
					ld_cond = 1'b1;
					reg_load[inst.as_setab.dst_b ? b : a] = 1'b1;
				end
			end
			mem:
			begin
				if (s[8] || s[9] || s[10])
				begin
					sel_m = 1'b1; // address from m
					if (inst.as_mem.store)
						reg_select[{1'b0, inst.as_mem.rsel}] = 1'b1;
					else
						mem_read = 1'b1;
				end
				if (s[9])
				begin
					if (inst.as_mem.store)
						mem_write = 1'b1;
					else
						reg_load[{1'b0, inst.as_mem.rsel}] = 1'b1;
				end
			end
			mov16:
			begin
				if (inst == op_halt)
				begin
					if (s[8] || s[9])
					begin
						data_out = 8'h00;
						data_drive = 1'b1;
					end
					if (s[9] || s[10])
						halt = 1'b1; // sequencer parks in state 10
				end
				else if (inst == op_return)
				begin
					if (s[8])
					begin
						sel_xy = 1'b1;
						ld_pc = 1'b1;
					end
				end
				else if (s[8])
				begin
					if (inst.as_mov16.from_j)
						sel_j = 1'b1;
					else
						sel_m = 1'b1;
					if (inst.as_mov16.to_xy)
						ld_xy = 1'b1;
					else
						ld_pc = 1'b1;
				end
			end
			inc:
			begin
				if (s[8])
				begin
					sel_xy = 1'b1;
					ld_inc = 1'b1;
				end
				if (s[11])
				begin
					sel_inc = 1'b1;
					ld_xy = 1'b1;
				end
			end
			goto_op:
			begin
				// two address bytes follow the opcode
				if (s[8] || s[9] || s[10] || s[15] || s[16] || s[17])
				begin
					sel_pc = 1'b1;
					mem_read = 1'b1;
				end
				if (s[9] || s[16])
					ld_inc = 1'b1;
				if (s[9])
				begin
					if (inst.as_goto.to_j)
						ld_j1 = 1'b1;
					else
						reg_load[m1] = 1'b1;
				end
				if (s[16])
				begin
					if (inst.as_goto.to_j)
						ld_j2 = 1'b1;
					else
						reg_load[m2] = 1'b1;
				end
				if (s[12] || s[19])
				begin
					sel_inc = 1'b1;
					ld_pc = 1'b1;
				end
				if (s[19] && inst.as_goto.call)
					ld_xy = 1'b1; // return address
				if (s[22] && branch_taken)
				begin
					sel_j = 1'b1;
					ld_pc = 1'b1;
				end
			end
			default:
			begin
				alu_func = alu_nop;
			end
		endcase
	end

endmodule

// ==== relay_control.sv ====
//**************************************************************************
// relay computer control unit top level
//**************************************************************************
module relay_control (
	input logic clk,
	input logic arst_n,
	input logic [7:0] data_in,
	input logic zero,
	input logic carry,
	input logic sign,
	output logic [7:0] reg_load,
	output logic [7:0] reg_select,
	output logic ld_inc,
	output logic ld_pc,
	output logic ld_xy,
	output logic ld_j1,
	output logic ld_j2,
	output logic ld_cond,
	output logic sel_pc,
	output logic sel_inc,
	output logic sel_m,
	output logic sel_j,
	output logic sel_xy,
	output logic mem_read,
	output logic mem_write,
	output logic data_drive,
	output logic halt,
	output logic [2:0] alu_func,
	output logic [7:0] data_out
);
	import relay_pkg::*;

	logic ld_inst;
	inst_word_t inst;
	inst_class_t inst_class;
	logic [num_states-1:0] state;

	inst_classifier u_classifier (
		.clk(clk),
		.arst_n(arst_n),
		.ld_inst(ld_inst),
		.data_in(data_in),
		.inst(inst),
		.inst_class(inst_class)
	);

	state_sequencer u_sequencer (
		.clk(clk),
		.arst_n(arst_n),
		.inst(inst),
		.inst_class(inst_class),
		.state(state)
	);

	control_decode u_decode (
		.state(state),
		.inst(inst),
		.inst_class(inst_class),
		.zero(zero),
		.carry(carry),
		.sign(sign),
		.reg_load(reg_load),
		.reg_select(reg_select),
		.ld_inst(ld_inst),
		.ld_inc(ld_inc),
		.ld_pc(ld_pc),
		.ld_xy(ld_xy),
		.ld_j1(ld_j1),
		.ld_j2(ld_j2),
		.ld_cond(ld_cond),
		.sel_pc(sel_pc),
		.sel_inc(sel_inc),
		.sel_m(sel_m),
		.sel_j(sel_j),
		.sel_xy(sel_xy),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.data_drive(data_drive),
		.halt(halt),
		.alu_func(alu_func),
		.data_out(data_out)
	);

endmodule

// ==== relay_tb_clock.sv ====
//**************************************************************************
// testbench clock and reset generator
//**************************************************************************
module relay_tb_clock (
	output logic clk,
	output logic arst_n
);
	localparam int period = 40;
	localparam int reset_cycles = 2;

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk); // release away from the rising edge
		arst_n = 1'b1;
	end

endmodule

// ==== relay_control_properties.sv ====
//**************************************************************************
// concurrent assertions on the control unit strobes, bound to the top level
//**************************************************************************
module relay_control_properties (
	input logic clk,
	input logic arst_n,
	input logic ld_inst,
	input logic mem_write,
	input logic [7:0] reg_load,
	input logic halt
);

	fetch_vs_write: assert property (@(posedge clk) disable iff (!arst_n)
		!(ld_inst && mem_write))
		else $error("ld_inst and mem_write high together");

	load_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(reg_load))
		else $error("more than one reg_load bit high");

	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		halt |=> halt)
		else $error("halt dropped before reset");

endmodule

bind relay_control relay_control_properties u_properties (
	.clk(clk),
	.arst_n(arst_n),
	.ld_inst(ld_inst),
	.mem_write(mem_write),
	.reg_load(reg_load),
	.halt(halt)
);

// ==== relay_control_tb.sv ====
//**************************************************************************
// testbench for the relay control unit: stimulus table, driver loop,
// strobe checks per instruction, halt check, timeout
//**************************************************************************
module relay_control_tb;
	import relay_pkg::*;

	localparam int max_rows = 20;
	localparam int drive_delay = 5;
	localparam int halt_window = 30;
	localparam int halt_first = 7; // state 9, counted from state 3

	logic clk;
	logic arst_n;
	logic [7:0] data_in;
	logic zero;
	logic carry;
	logic sign;
	logic [7:0] reg_load;
	logic [7:0] reg_select;
	logic ld_inc;
	logic ld_pc;
	logic ld_xy;
	logic ld_j1;
	logic ld_j2;
	logic ld_cond;
	logic sel_pc;
	logic sel_inc;
	logic sel_m;
	logic sel_j;
	logic sel_xy;
	logic mem_read;
	logic mem_write;
	logic data_drive;
	logic halt;
	logic [2:0] alu_func;
	logic [7:0] data_out;

	// stimulus table, one entry per instruction
	logic [7:0] row_inst [max_rows];
	logic [2:0] row_flags [max_rows]; // sign, carry, zero
	int row_len [max_rows];
	logic [7:0] row_load [max_rows];
	int row_drive [max_rows];
	logic [7:0] row_data [max_rows];
	logic [2:0] row_func [max_rows];
	int row_rd [max_rows];
	int row_wr [max_rows];
	int row_xy [max_rows];
	int row_jump [max_rows];
	logic [7:0] row_sel [max_rows];
	logic [7:0] row_strobes [max_rows];
	int row_count;

	int cycle_count;
	int cycle_limit;

	relay_tb_clock u_clock (
		.clk(clk),
		.arst_n(arst_n)
	);

	relay_control UUT (
		.clk(clk),
		.arst_n(arst_n),
		.data_in(data_in),
		.zero(zero),
		.carry(carry),
		.sign(sign),
		.reg_load(reg_load),
		.reg_select(reg_select),
		.ld_inc(ld_inc),
		.ld_pc(ld_pc),
		.ld_xy(ld_xy),
		.ld_j1(ld_j1),
		.ld_j2(ld_j2),
		.ld_cond(ld_cond),
		.sel_pc(sel_pc),
		.sel_inc(sel_inc),
		.sel_m(sel_m),
		.sel_j(sel_j),
		.sel_xy(sel_xy),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.data_drive(data_drive),
		.halt(halt),
		.alu_func(alu_func),
		.data_out(data_out)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERR %0t %s: got %0h, expected %0h", $time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// bits under mask are don't-care fields, filled at random
	task automatic add_row(input logic [7:0] inst, input logic [7:0] mask,
		input logic [2:0] flags, input int len, input logic [7:0] load,
		input int drive, input logic [7:0] data, input logic [2:0] func,
		input int rd, input int wr, input int xy, input int jump,
		input logic [15:0] sel_strobes);
		row_inst[row_count] = (inst & ~mask) | (8'($urandom) & mask);
		row_flags[row_count] = flags;
		row_len[row_count] = len;
		row_load[row_count] = load;
		row_drive[row_count] = drive;
		row_data[row_count] = data;
		row_func[row_count] = func;
		row_rd[row_count] = rd;
		row_wr[row_count] = wr;
		row_xy[row_count] = xy;
		row_jump[row_count] = jump;
		row_sel[row_count] = sel_strobes[15:8];
		row_strobes[row_count] = sel_strobes[7:0];
		row_count++;
	endtask

	task automatic build_table();
		row_count = 0;
		// inst, mask, flags, len, load, drive, data, func, rd, wr, xy, jump, {select, strobes}
		// strobe mask bits from msb ld_inc ld_j1 ld_j2 ld_cond sel_m sel_xy sel_inc halt
		add_row(8'h11, 8'h00, 3'b000, len_short, 8'h04, 0, 8'h00, alu_nop, 0, 0, 0, 0, 16'h0202);
		add_row(8'h82, 8'h00, 3'b000, len_short, 8'h01, 0, 8'h00, 3'b010, 0, 0, 0, 0, 16'h0002);
		add_row(8'h8D, 8'h00, 3'b000, len_short, 8'h08, 0, 8'h00, 3'b101, 0, 0, 0, 0, 16'h0002);
		add_row(8'h4A, 8'h00, 3'b000, len_short, 8'h01, 3, 8'h0A, alu_nop, 0, 0, 0, 0, 16'h0012);
		add_row(8'h73, 8'h00, 3'b000, len_short, 8'h02, 3, 8'hF3, alu_nop, 0, 0, 0, 0, 16'h0012);
		add_row(8'h92, 8'h04, 3'b000, len_mem, 8'h04, 0, 8'h00, alu_nop, 3, 0, 0, 0, 16'h000A);
		add_row(8'h9B, 8'h04, 3'b000, len_mem, 8'h00, 0, 8'h00, alu_nop, 0, 1, 0, 0, 16'h080A);
		add_row(8'hA4, 8'h03, 3'b000, len_mem, 8'h00, 0, 8'h00, alu_nop, 0, 0, 0, 1, 16'h0002);
		add_row(8'hA0, 8'h03, 3'b000, len_mem, 8'h00, 0, 8'h00, alu_nop, 0, 0, 0, 0, 16'h000A);
		add_row(op_return, 8'h00, 3'b000, len_mem, 8'h00, 0, 8'h00, alu_nop, 0, 0, 0, 0, 16'h0006);
		add_row(8'hB0, 8'h0F, 3'b000, len_inc, 8'h00, 0, 8'h00, alu_nop, 0, 0, 1, 0, 16'h0086);
		add_row(8'hE0, 8'h00, 3'b000, len_goto, 8'h00, 0, 8'h00, alu_nop, 0, 0, 0, 1, 16'h00E2);
		add_row(8'hC5, 8'h00, 3'b001, len_goto, 8'h30, 0, 8'h00, alu_nop, 0, 0, 1, 1, 16'h0082);
		add_row(8'hF8, 8'h00, 3'b000, len_goto, 8'h00, 0, 8'h00, alu_nop, 0, 0, 0, 0, 16'h00E2);
		add_row(8'hE3, 8'h00, 3'b001, len_goto, 8'h00, 0, 8'h00, alu_nop, 0, 0, 1, 0, 16'h00E2);
		add_row(8'hC2, 8'h00, 3'b100, len_goto, 8'h30, 0, 8'h00, alu_nop, 0, 0, 0, 1, 16'h0082);
		add_row(op_halt, 8'h00, 3'b000, len_mem, 8'h00, 2, 8'h00, alu_nop, 0, 0, 0, 0, 16'h0000);
		cycle_limit = 50;
		for (int i = 0; i < row_count; i++)
			cycle_limit += row_len[i];
	endtask

	task automatic wait_first_load();
		@(negedge clk);
		while (!UUT.ld_inst)
			@(negedge clk);
	endtask

	// watch one instruction from state 3 up to the next ld_inst
	task automatic measure_instruction(input int idx);
		int cycles;
		logic [7:0] load_or;
		logic [7:0] sel_or;
		logic [7:0] strobe_or;
		int drive_cnt;
		int func_cnt;
		int rd_cnt;
		int wr_cnt;
		int xy_cnt;
		int jump_cnt;
		int sel_j_cnt;
		cycles = 0;
		load_or = '0;
		sel_or = '0;
		strobe_or = '0;
		drive_cnt = 0;
		func_cnt = 0;
		rd_cnt = 0;
		wr_cnt = 0;
		xy_cnt = 0;
		jump_cnt = 0;
		sel_j_cnt = 0;
		forever
		begin
			@(negedge clk);
			cycles++;
			if (UUT.ld_inst)
				break;
			load_or = load_or | reg_load;
			sel_or = sel_or | reg_select;
			strobe_or = strobe_or |
				{ld_inc, ld_j1, ld_j2, ld_cond, sel_m, sel_xy, sel_inc, halt};
			if (data_drive)
			begin
				drive_cnt++;
				check_value("data_out", 32'(data_out), 32'(row_data[idx]));
			end
			if (alu_func != alu_nop)
			begin
				func_cnt++;
				check_value("alu_func", 32'(alu_func), 32'(row_func[idx]));
			end
			if (mem_read && !sel_pc)
				rd_cnt++; // fetch reads always come with sel_pc
			if (mem_write)
				wr_cnt++;
			if (ld_xy)
				xy_cnt++;
			if (sel_j)
				sel_j_cnt++;
			if (sel_j && ld_pc)
				jump_cnt++;
		end
		check_value("length", cycles, row_len[idx]);
		check_value("reg_load", 32'(load_or), 32'(row_load[idx]));
		check_value("reg_select", 32'(sel_or), 32'(row_sel[idx]));
		check_value("strobe mask", 32'(strobe_or), 32'(row_strobes[idx]));
		check_value("data_drive", drive_cnt, row_drive[idx]);
		check_value("alu_func cycles", func_cnt, (row_func[idx] == alu_nop) ? 0 : 3);
		check_value("mem_read", rd_cnt, row_rd[idx]);
		check_value("mem_write", wr_cnt, row_wr[idx]);
		check_value("ld_xy", xy_cnt, row_xy[idx]);
		check_value("sel_j with ld_pc", jump_cnt, row_jump[idx]);
		check_value("sel_j", sel_j_cnt, row_jump[idx]);
	endtask

	task automatic watch_halt();
		for (int k = 1; k <= halt_window; k++)
		begin
			@(negedge clk);
			check_value("ld_inst", 32'(UUT.ld_inst), 32'(0));
			check_value("halt", 32'(halt), 32'(k >= halt_first));
			if (k == halt_first - 1 || k == halt_first)
			begin
				check_value("data_drive", 32'(data_drive), 32'(1));
				check_value("data_out", 32'(data_out), 32'(0));
			end
		end
	endtask

	initial
	begin
		data_in = 8'h00;
		zero = 1'b0;
		carry = 1'b0;
		sign = 1'b0;
		cycle_count = 0;
		cycle_limit = 1000;
		void'($urandom(32'h0732_7a71));
		build_table();
		data_in = row_inst[0];
		wait_first_load();
		for (int i = 0; i < row_count; i++)
		begin
			@(posedge clk);
			#drive_delay;
			data_in = (i + 1 < row_count) ? row_inst[i + 1] : 8'h00;
			{sign, carry, zero} = row_flags[i];
			if (row_inst[i] == op_halt)
				watch_halt();
			else
				measure_instruction(i);
		end
		$display("Test completed successfully");
		$finish;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout after %0d cycles, an instruction did not finish", cycle_count);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

endmodule

// ==== sources.f ====
relay_pkg.sv
inst_classifier.sv
state_sequencer.sv
control_decode.sv
relay_control.sv
relay_tb_clock.sv
relay_control_properties.sv
relay_control_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the relay control testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module relay_control_tb -f sources.f \
	-o relay_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/relay_sim > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
